//--- logic/lc4_alu.sv
/* X-stage ALU for the kept subset, also forms the branch target.
   Purely combinational, fed from the D-to-X register and the bypass muxes */
module lc4_alu (
  input  lc4_pkg::alu_op_t i_op,
  input  lc4_pkg::word_t   i_a,   // rs operand after bypass
  input  lc4_pkg::word_t   i_b,   // rt operand after bypass
  input  lc4_pkg::word_t   i_imm, // Already sign-extended
  input  lc4_pkg::word_t   i_pc,
  output lc4_pkg::word_t   o_result
);

  always_comb begin
    case (i_op)
      lc4_pkg::ALU_ADD: begin
        o_result = i_a + i_b;
      end
      lc4_pkg::ALU_ADDI: begin
        o_result = i_a + i_imm;
      end
      lc4_pkg::ALU_AND: begin
        o_result = i_a & i_b;
      end
      lc4_pkg::ALU_CONST: begin
        o_result = i_imm;
      end
      lc4_pkg::ALU_BRTGT: begin
        o_result = i_pc + 16'd1 + i_imm; // Offset is relative to the next PC
      end
      default: begin
        o_result = '0;
      end
    endcase
  end

endmodule

//--- logic/lc4_core.sv
/* Top of the four-stage LC4 core, connects fetch, decode, register file and execute.
   Instruction memory sits outside on o_cur_pc and i_cur_insn */
module lc4_core (
  input  logic              gwe,
  input  logic              i_arst_n,
  output lc4_pkg::word_t    o_cur_pc,
  input  lc4_pkg::word_t    i_cur_insn,
  output logic              o_commit_valid,
  output lc4_pkg::word_t    o_commit_pc,
  output lc4_pkg::word_t    o_commit_insn,
  output logic              o_commit_regfile_we,
  output lc4_pkg::reg_sel_t o_commit_wsel,
  output lc4_pkg::word_t    o_commit_data,
  output logic              o_commit_nzp_we,
  output lc4_pkg::nzp_t     o_commit_nzp
);

  lc4_pkg::word_t    d_pc, d_insn;
  logic              squash;
  lc4_pkg::word_t    branch_target;
  // Decode outputs
  lc4_pkg::reg_sel_t rs, rt, rd;
  logic              regfile_we, nzp_we, is_branch;
  lc4_pkg::alu_op_t  alu_op;
  lc4_pkg::word_t    imm;
  lc4_pkg::nzp_t     br_cond;
  // Register file ports
  lc4_pkg::word_t    rs_data, rt_data;
  lc4_pkg::reg_sel_t wsel;
  lc4_pkg::word_t    wdata;
  logic              we;

  lc4_fetch fetch_i (
    .gwe             (gwe),
    .i_arst_n        (i_arst_n),
    .i_cur_insn      (i_cur_insn),
    .i_squash        (squash),
    .i_branch_target (branch_target),
    .o_cur_pc        (o_cur_pc),
    .o_d_pc          (d_pc),
    .o_d_insn        (d_insn)
  );

  lc4_decoder decoder_i (
    .i_insn       (d_insn),
    .o_rs         (rs),
    .o_rt         (rt),
    .o_rd         (rd),
    .o_regfile_we (regfile_we),
    .o_nzp_we     (nzp_we),
    .o_is_branch  (is_branch),
    .o_alu_op     (alu_op),
    .o_imm        (imm),
    .o_br_cond    (br_cond)
  );

  lc4_regfile regfile_i (
    .gwe       (gwe),
    .i_arst_n  (i_arst_n),
    .i_rs      (rs),
    .i_rt      (rt),
    .i_wsel    (wsel), // Written from W
    .i_wdata   (wdata),
    .i_we      (we),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  lc4_execute execute_i (
    .gwe                 (gwe),
    .i_arst_n            (i_arst_n),
    .i_rs                (rs),
    .i_rt                (rt),
    .i_rd                (rd),
    .i_regfile_we        (regfile_we),
    .i_nzp_we            (nzp_we),
    .i_is_branch         (is_branch),
    .i_alu_op            (alu_op),
    .i_imm               (imm),
    .i_br_cond           (br_cond),
    .i_d_pc              (d_pc),
    .i_d_insn            (d_insn),
    .i_rs_data           (rs_data),
    .i_rt_data           (rt_data),
    .o_squash            (squash),
    .o_branch_target     (branch_target),
    .o_wsel              (wsel),
    .o_wdata             (wdata),
    .o_we                (we),
    .o_commit_valid      (o_commit_valid),
    .o_commit_pc         (o_commit_pc),
    .o_commit_insn       (o_commit_insn),
    .o_commit_regfile_we (o_commit_regfile_we),
    .o_commit_wsel       (o_commit_wsel),
    .o_commit_data       (o_commit_data),
    .o_commit_nzp_we     (o_commit_nzp_we),
    .o_commit_nzp        (o_commit_nzp)
  );

endmodule

//--- logic/lc4_decoder.sv
/* Combinational decode of the LC4 subset into register selects and X-stage controls.
   Opcodes outside the subset decode with every write enable low */
module lc4_decoder (
  input  lc4_pkg::word_t    i_insn,
  output lc4_pkg::reg_sel_t o_rs,
  output lc4_pkg::reg_sel_t o_rt,
  output lc4_pkg::reg_sel_t o_rd,
  output logic              o_regfile_we,
  output logic              o_nzp_we,
  output logic              o_is_branch,
  output lc4_pkg::alu_op_t  o_alu_op,
  output lc4_pkg::word_t    o_imm,     // Sign-extended immediate
  output lc4_pkg::nzp_t     o_br_cond  // BR condition bits
);

  always_comb begin
    // Source fields sit at the same place in every kept format
    o_rs         = i_insn[8:6];
    o_rt         = i_insn[2:0];
    o_rd         = '0; // Zero unless the insn writes
    o_regfile_we = 1'b0;
    o_nzp_we     = 1'b0;
    o_is_branch  = 1'b0;
    o_alu_op     = lc4_pkg::ALU_ADD;
    o_imm        = '0;
    o_br_cond    = '0;
    case (lc4_pkg::opcode_t'(i_insn[15:12]))
      lc4_pkg::OP_BR: begin
        o_is_branch = 1'b1;
        o_br_cond   = i_insn[11:9];
        o_imm       = {{7{i_insn[8]}}, i_insn[8:0]}; // imm9 offset
        o_alu_op    = lc4_pkg::ALU_BRTGT;
      end
      lc4_pkg::OP_ADD: begin
        if (i_insn[5]) begin // ADDI, imm5 form
          o_rd         = i_insn[11:9];
          o_regfile_we = 1'b1;
          o_nzp_we     = 1'b1;
          o_imm        = {{11{i_insn[4]}}, i_insn[4:0]};
          o_alu_op     = lc4_pkg::ALU_ADDI;
        end else if (i_insn[5:3] == lc4_pkg::FUNC_ADD) begin
          o_rd         = i_insn[11:9];
          o_regfile_we = 1'b1;
          o_nzp_we     = 1'b1;
          o_alu_op     = lc4_pkg::ALU_ADD;
        end
        // MUL, SUB and DIV fall through as no-write
      end
      lc4_pkg::OP_AND: begin
        if (i_insn[5:3] == lc4_pkg::FUNC_AND) begin
          o_rd         = i_insn[11:9];
          o_regfile_we = 1'b1;
          o_nzp_we     = 1'b1;
          o_alu_op     = lc4_pkg::ALU_AND;
        end
      end
      lc4_pkg::OP_CONST: begin
        o_rd         = i_insn[11:9];
        o_regfile_we = 1'b1;
        o_nzp_we     = 1'b1;
        o_imm        = {{7{i_insn[8]}}, i_insn[8:0]};
        o_alu_op     = lc4_pkg::ALU_CONST;
      end
      default: ; // Unsupported, all controls stay inactive
    endcase
  end

endmodule

//--- logic/lc4_execute.sv
/* Execute and writeback: D-to-X and X-to-W registers, W-to-X bypass, NZP and branch
   resolution. The W register drives the register file write port and the commit trace */
module lc4_execute (
  input  logic              gwe,
  input  logic              i_arst_n,
  // Decoded D-stage controls
  input  lc4_pkg::reg_sel_t i_rs,
  input  lc4_pkg::reg_sel_t i_rt,
  input  lc4_pkg::reg_sel_t i_rd,
  input  logic              i_regfile_we,
  input  logic              i_nzp_we,
  input  logic              i_is_branch,
  input  lc4_pkg::alu_op_t  i_alu_op,
  input  lc4_pkg::word_t    i_imm,
  input  lc4_pkg::nzp_t     i_br_cond,
  input  lc4_pkg::word_t    i_d_pc,
  input  lc4_pkg::word_t    i_d_insn,
  input  lc4_pkg::word_t    i_rs_data,
  input  lc4_pkg::word_t    i_rt_data,
  output logic              o_squash,        // Taken branch, one cycle
  output lc4_pkg::word_t    o_branch_target,
  // Register file write port
  output lc4_pkg::reg_sel_t o_wsel,
  output lc4_pkg::word_t    o_wdata,
  output logic              o_we,
  // Commit trace
  output logic              o_commit_valid,
  output lc4_pkg::word_t    o_commit_pc,
  output lc4_pkg::word_t    o_commit_insn,
  output logic              o_commit_regfile_we,
  output lc4_pkg::reg_sel_t o_commit_wsel,
  output lc4_pkg::word_t    o_commit_data,
  output logic              o_commit_nzp_we,
  output lc4_pkg::nzp_t     o_commit_nzp
);

  logic              d_vld_q; // D latch holds a fetched word, not a bubble
  // X stage
  logic              x_vld_q, x_regfile_we_q, x_nzp_we_q, x_is_branch_q;
  lc4_pkg::alu_op_t  x_alu_op_q;
  lc4_pkg::nzp_t     x_br_cond_q;
  lc4_pkg::reg_sel_t x_rs_q, x_rt_q, x_rd_q;
  lc4_pkg::word_t    x_pc_q, x_insn_q, x_imm_q, x_rs_data_q, x_rt_data_q;
  lc4_pkg::word_t    x_a, x_b, x_result;
  lc4_pkg::nzp_t     x_nzp;
  lc4_pkg::nzp_t     nzp_q; // Architectural condition codes
  // W stage
  logic              w_vld_q, w_we_q, w_nzp_we_q;
  lc4_pkg::reg_sel_t w_wsel_q;
  lc4_pkg::word_t    w_pc_q, w_insn_q, w_data_q;
  lc4_pkg::nzp_t     w_nzp_q;

  // Bubble tracking, the D latch is empty after reset and after a squash
  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      d_vld_q <= 1'b0;
    end else begin
      d_vld_q <= ~o_squash;
    end
  end

  // D-to-X controls, cleared on squash
  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      x_vld_q        <= 1'b0;
      x_regfile_we_q <= 1'b0;
      x_nzp_we_q     <= 1'b0;
      x_is_branch_q  <= 1'b0;
      x_alu_op_q     <= lc4_pkg::ALU_ADD;
      x_br_cond_q    <= '0;
    end else if (o_squash) begin
      x_vld_q        <= 1'b0;
      x_regfile_we_q <= 1'b0;
      x_nzp_we_q     <= 1'b0;
      x_is_branch_q  <= 1'b0;
      x_alu_op_q     <= lc4_pkg::ALU_ADD;
      x_br_cond_q    <= '0;
    end else begin
      x_vld_q        <= d_vld_q;
      x_regfile_we_q <= i_regfile_we;
      x_nzp_we_q     <= i_nzp_we;
      x_is_branch_q  <= i_is_branch;
      x_alu_op_q     <= i_alu_op;
      x_br_cond_q    <= i_br_cond;
    end
  end

  always_ff @(posedge gwe) begin
    x_rs_q      <= i_rs;
    x_rt_q      <= i_rt;
    x_rd_q      <= i_rd;
    x_pc_q      <= i_d_pc;
    x_insn_q    <= o_squash ? lc4_pkg::NOP_INSN : i_d_insn;
    x_imm_q     <= i_imm;
    x_rs_data_q <= i_rs_data;
    x_rt_data_q <= i_rt_data;
  end

  // W-to-X bypass for a producer one ahead
  assign x_a = (w_we_q && (w_wsel_q == x_rs_q)) ? w_data_q : x_rs_data_q;
  assign x_b = (w_we_q && (w_wsel_q == x_rt_q)) ? w_data_q : x_rt_data_q;

  lc4_alu alu_i (
    .i_op     (x_alu_op_q),
    .i_a      (x_a),
    .i_b      (x_b),
    .i_imm    (x_imm_q),
    .i_pc     (x_pc_q),
    .o_result (x_result)
  );

  // Sign rule on the 16-bit result
  assign x_nzp = {x_result[15], (x_result == '0), (~x_result[15] & (|x_result))};

  // NZP written as the producer leaves X, so a branch right behind it sees the update
  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      nzp_q <= '0;
    end else if (x_nzp_we_q) begin
      nzp_q <= x_nzp;
    end
  end

  assign o_squash        = x_is_branch_q && |(x_br_cond_q & nzp_q);
  assign o_branch_target = x_result;

  // X-to-W
  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      w_vld_q    <= 1'b0;
      w_we_q     <= 1'b0;
      w_nzp_we_q <= 1'b0;
    end else begin
      w_vld_q    <= x_vld_q;
      w_we_q     <= x_regfile_we_q;
      w_nzp_we_q <= x_nzp_we_q;
    end
  end

  always_ff @(posedge gwe) begin
    w_wsel_q <= x_rd_q;
    w_pc_q   <= x_pc_q;
    w_insn_q <= x_insn_q;
    w_data_q <= x_result;
    w_nzp_q  <= x_nzp_we_q ? x_nzp : nzp_q; // NZP state after this insn
  end

  assign o_wsel  = w_wsel_q;
  assign o_wdata = w_data_q;
  assign o_we    = w_we_q;

  assign o_commit_valid      = w_vld_q;
  assign o_commit_pc         = w_pc_q;
  assign o_commit_insn       = w_insn_q;
  assign o_commit_regfile_we = w_we_q;
  assign o_commit_wsel       = w_wsel_q;
  assign o_commit_data       = w_data_q;
  assign o_commit_nzp_we     = w_nzp_we_q;
  assign o_commit_nzp        = w_nzp_q;

endmodule

//--- logic/lc4_fetch.sv
/* Fetch stage: PC register with next-PC select and the F-to-D instruction latch.
   A squash from execute redirects the PC and turns the fetched word into a NOP */
module lc4_fetch (
  input  logic           gwe,
  input  logic           i_arst_n,
  input  lc4_pkg::word_t i_cur_insn,      // Word at o_cur_pc, same cycle
  input  logic           i_squash,        // Taken branch in X
  input  lc4_pkg::word_t i_branch_target, // Redirect address from X
  output lc4_pkg::word_t o_cur_pc,
  output lc4_pkg::word_t o_d_pc,
  output lc4_pkg::word_t o_d_insn
);

  lc4_pkg::word_t pc_q;
  lc4_pkg::word_t pc_next;
  lc4_pkg::word_t d_pc_q;
  lc4_pkg::word_t d_insn_q;

  // Sequential fetch unless X redirects
  assign pc_next = i_squash ? i_branch_target : pc_q + 16'd1;

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q <= lc4_pkg::RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // Fetched word for decode, killed on squash
  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      d_insn_q <= lc4_pkg::NOP_INSN;
    end else if (i_squash) begin
      d_insn_q <= lc4_pkg::NOP_INSN; // Younger of the two squashed words
    end else begin
      d_insn_q <= i_cur_insn;
    end
  end

  // PC travels with the word
  always_ff @(posedge gwe) begin
    d_pc_q <= pc_q;
  end

  assign o_cur_pc = pc_q;
  assign o_d_pc   = d_pc_q;
  assign o_d_insn = d_insn_q;

endmodule

//--- logic/lc4_pkg.sv
/* Shared LC4 core definitions: machine widths, opcode and ALU encodings, reset PC.
   Referenced by every RTL file as lc4_pkg:: scoped names */
package lc4_pkg;

  typedef logic [15:0] word_t;    // PC, instruction and register data
  typedef logic [2:0]  reg_sel_t; // Register index, R0 to R7
  typedef logic [2:0]  nzp_t;     // {n, z, p}

  // Top four instruction bits of the supported subset
  typedef enum logic [3:0] {
    OP_BR    = 4'b0000, // Conditional branch, zero condition bits is NOP
    OP_ADD   = 4'b0001, // Arithmetic group, only ADD and ADDI kept
    OP_AND   = 4'b0101, // Logical group, only AND kept
    OP_CONST = 4'b1001  // Load signed 9-bit immediate
  } opcode_t;

  // Decoded ALU function, carried from decode into X
  typedef enum logic [2:0] {
    ALU_ADD,   // rs + rt
    ALU_ADDI,  // rs + sext(imm5)
    ALU_AND,   // rs & rt
    ALU_CONST, // sext(imm9)
    ALU_BRTGT  // pc + 1 + sext(imm9)
  } alu_op_t;

  // Sub-op field insn[5:3] for the register forms
  localparam logic [2:0] FUNC_ADD = 3'b000;
  localparam logic [2:0] FUNC_AND = 3'b000;

  localparam word_t RESET_PC = 16'h8200; // First fetch address
  localparam int    NUM_REGS = 8;
  localparam word_t NOP_INSN = 16'h0000; // BR with no condition bits

endpackage

//--- logic/lc4_regfile.sv
/* Eight 16-bit registers, written from W and read in D.
   Same-cycle writes pass straight through to the read ports */
module lc4_regfile (
  input  logic              gwe,
  input  logic              i_arst_n,
  input  lc4_pkg::reg_sel_t i_rs,
  input  lc4_pkg::reg_sel_t i_rt,
  input  lc4_pkg::reg_sel_t i_wsel,
  input  lc4_pkg::word_t    i_wdata,
  input  logic              i_we,
  output lc4_pkg::word_t    o_rs_data,
  output lc4_pkg::word_t    o_rt_data
);

  lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
        regs[i] <= '0; // Architectural registers start at zero
      end
    end else if (i_we) begin
      regs[i_wsel] <= i_wdata;
    end
  end

  // Write-through covers a producer two ahead of the reader
  assign o_rs_data = (i_we && (i_wsel == i_rs)) ? i_wdata : regs[i_rs];
  assign o_rt_data = (i_we && (i_wsel == i_rt)) ? i_wdata : regs[i_rt];

endmodule

//--- tb.f
logic/lc4_pkg.sv
logic/lc4_alu.sv
logic/lc4_fetch.sv
logic/lc4_decoder.sv
logic/lc4_regfile.sv
logic/lc4_execute.sv
logic/lc4_core.sv
tb/lc4_clkgen.sv
tb/lc4_checker.sv
tb/tb_lc4.sv

//--- tb/lc4_checker.sv
/* Commit-trace checker for the LC4 testbench, compares every committed instruction with
   the next expected record and reports each test as it finishes */
module lc4_checker (
  input  logic              gwe,
  input  logic              i_arst_n,
  input  logic              i_commit_valid,
  input  lc4_pkg::word_t    i_commit_pc,
  input  lc4_pkg::word_t    i_commit_insn,
  input  logic              i_commit_regfile_we,
  input  lc4_pkg::reg_sel_t i_commit_wsel,
  input  lc4_pkg::word_t    i_commit_data,
  input  logic              i_commit_nzp_we,
  input  lc4_pkg::nzp_t     i_commit_nzp,
  input  lc4_pkg::word_t    i_exp_test, // Fields of record o_rec_idx
  input  lc4_pkg::word_t    i_exp_pc,
  input  lc4_pkg::word_t    i_exp_insn,
  input  lc4_pkg::word_t    i_exp_we,
  input  lc4_pkg::word_t    i_exp_wsel,
  input  lc4_pkg::word_t    i_exp_data,
  input  lc4_pkg::word_t    i_exp_nzp_we,
  input  lc4_pkg::word_t    i_exp_nzp,
  input  int                i_num_recs,
  input  logic              i_timeout,  // Run ended by the cycle limit
  output int                o_rec_idx,
  output logic              o_done,
  output int                o_errors,
  output int                o_tests_passed,
  output int                o_tests_failed
);

  int             rec_idx      = 0;
  int             errors       = 0;
  int             tests_passed = 0;
  int             tests_failed = 0;
  int             test_errs    = 0; // Mismatches in the running test
  int             test_commits = 0;
  logic           test_active  = 1'b0;
  lc4_pkg::word_t cur_test     = '0;

  task automatic check_field(input string name, input lc4_pkg::word_t exp_val,
                             input lc4_pkg::word_t act_val);
    if (act_val !== exp_val) begin
      $display("ERROR %s expected %h got %h at pc %h", name, exp_val, act_val, i_exp_pc);
      errors++;
      test_errs++;
    end
  endtask

  // One line per finished test
  task automatic close_test();
    if (test_errs == 0) begin
      $display("Test %0d passed, %0d commits", cur_test, test_commits);
      tests_passed++;
    end else begin
      $display("Test %0d failed, %0d errors", cur_test, test_errs);
      tests_failed++;
    end
    test_errs    = 0;
    test_commits = 0;
    test_active  = 1'b0;
  endtask

  // Commit ports are sampled on the edge, before the W register moves
  always @(posedge gwe) begin
    if (i_arst_n && i_commit_valid && !i_timeout) begin
      if (rec_idx >= i_num_recs) begin
        $display("Unexpected commit at pc %h after the last expected record", i_commit_pc);
        errors++;
      end else begin
        if (test_active && (i_exp_test != cur_test)) begin
          close_test();
        end
        cur_test    = i_exp_test;
        test_active = 1'b1;
        test_commits++;
        check_field("o_commit_pc", i_exp_pc, i_commit_pc);
        check_field("o_commit_insn", i_exp_insn, i_commit_insn);
        check_field("o_commit_regfile_we", i_exp_we, i_commit_regfile_we);
        check_field("o_commit_nzp_we", i_exp_nzp_we, i_commit_nzp_we);
        if (i_exp_we[0]) begin // Target and data only matter for a register write
          check_field("o_commit_wsel", i_exp_wsel, i_commit_wsel);
          check_field("o_commit_data", i_exp_data, i_commit_data);
        end
        if (i_exp_nzp_we[0]) begin
          check_field("o_commit_nzp", i_exp_nzp, i_commit_nzp);
        end
        rec_idx++;
        if (rec_idx == i_num_recs) begin
          close_test(); // Last record closes the last test
        end
      end
    end
  end

  always @(posedge i_timeout) begin
    $display("Too few commits, %0d of %0d expected records seen before the timeout",
             rec_idx, i_num_recs);
    errors++;
    if (test_active) begin
      test_errs++;
      close_test();
    end
  end

  assign o_rec_idx      = rec_idx;
  assign o_done         = (i_num_recs > 0) && (rec_idx == i_num_recs);
  assign o_errors       = errors;
  assign o_tests_passed = tests_passed;
  assign o_tests_failed = tests_failed;

endmodule

//--- tb/lc4_clkgen.sv
/* Testbench clock and reset for the LC4 core.
   gwe runs with a period of 100, reset is held low for the first 8 rising edges */
module lc4_clkgen (
  output logic o_gwe,
  output logic o_arst_n
);

  initial begin
    o_gwe    = 1'b0;
    o_arst_n = 1'b0; // Core in reset from time zero
    repeat (8) @(posedge o_gwe);
    o_arst_n <= 1'b1; // Released on a rising edge, first live edge is the next one
  end

  always #50 o_gwe = ~o_gwe; // Period 100

endmodule

//--- tb/lc4_testdata.hex
// Program words from @0000, indexed by PC minus 8200 hex, one line per test
// Records from @0100: test pc insn regfile_we wsel data nzp_we nzp, test 0 ends the list
@0000
0000 9201 9402 9603                                // 1: NOP, CONST R1..R3
93fc 1467 1681 18c3 1b30 1d42 9eff 11c6            // 2: dependent ADD/ADDI chain
92f0 95ff 5642 5882 9a0f 5d41 5f03                 // 3: AND with n, z, p results
9200 0403 9411 9622 9833 1a41 1c83 0202 9e01 9e02 1fe0 // 4: taken BRz, BRp
93fe 0604 1262 0a05 01f0 9455 1681                 // 5: not-taken BR, BR as NOP
@0100
// Test 1, reset and program order
1 8200 0000 0 0 0000 0 0
1 8201 9201 1 1 0001 1 1
1 8202 9402 1 2 0002 1 1
1 8203 9603 1 3 0003 1 1
// Test 2, bypass and write-through, 16-bit wrap on the last ADD
2 8204 93fc 1 1 fffc 1 4
2 8205 1467 1 2 0003 1 1
2 8206 1681 1 3 ffff 1 4
2 8207 18c3 1 4 fffe 1 4
2 8208 1b30 1 5 ffee 1 4
2 8209 1d42 1 6 fff1 1 4
2 820a 9eff 1 7 00ff 1 1
2 820b 11c6 1 0 00f0 1 1
// Test 3, AND and condition codes
3 820c 92f0 1 1 00f0 1 1
3 820d 95ff 1 2 ffff 1 4
3 820e 5642 1 3 00f0 1 1
3 820f 5882 1 4 ffff 1 4
3 8210 9a0f 1 5 000f 1 1
3 8211 5d41 1 6 0000 1 2
3 8212 5f03 1 7 00f0 1 1
// Test 4, taken branches, squashed words leave R2, R3 and R7 alone
4 8213 9200 1 1 0000 1 2
4 8214 0403 0 0 0000 0 0
4 8218 1a41 1 5 0000 1 2
4 8219 1c83 1 6 00ef 1 1
4 821a 0202 0 0 0000 0 0
4 821d 1fe0 1 7 00f0 1 1
// Test 5, not-taken branches and a zero-condition BR
5 821e 93fe 1 1 fffe 1 4
5 821f 0604 0 0 0000 0 0
5 8220 1262 1 1 0000 1 2
5 8221 0a05 0 0 0000 0 0
5 8222 01f0 0 0 0000 0 0
5 8223 9455 1 2 0055 1 1
5 8224 1681 1 3 0055 1 1
// End of list
0 0000 0000 0 0 0000 0 0

//--- tb/tb_lc4.sv
/* Testbench top for the LC4 core: loads the program image and expected commits from the
   test data file, serves instruction fetches and ends the run at a cycle limit */
module tb_lc4;

  localparam int PROG_WORDS = 256; // Program image at 000 to 0ff
  localparam int REC_BASE   = 256; // Expected records from 100
  localparam int REC_WORDS  = 8;   // test pc insn we wsel data nzp_we nzp
  localparam int MAX_RECS   = 96;

  lc4_pkg::word_t    tdata [0:1023];
  logic              loaded = 1'b0;
  logic              gwe;
  logic              arst_n;
  lc4_pkg::word_t    cur_pc;
  lc4_pkg::word_t    cur_insn = lc4_pkg::NOP_INSN;
  logic              commit_valid, commit_regfile_we, commit_nzp_we;
  lc4_pkg::word_t    commit_pc, commit_insn, commit_data;
  lc4_pkg::reg_sel_t commit_wsel;
  lc4_pkg::nzp_t     commit_nzp;
  lc4_pkg::word_t    exp_rec [REC_WORDS]; // Record the checker is waiting for
  int                rec_idx;
  logic              done;
  logic              timed_out = 1'b0;
  int                errors, tests_passed, tests_failed;
  int                num_recs, num_taken, limit, cycles;

  // Image word at a PC, NOP outside the loaded program
  function automatic lc4_pkg::word_t fetch_word(input lc4_pkg::word_t pc);
    lc4_pkg::word_t offs;
    offs = pc - lc4_pkg::RESET_PC;
    if ($isunknown(pc) || (offs >= PROG_WORDS) || $isunknown(tdata[offs])) begin
      return lc4_pkg::NOP_INSN;
    end
    return tdata[offs];
  endfunction

  function automatic lc4_pkg::word_t rec_field(input int idx, input int field);
    return tdata[REC_BASE + REC_WORDS * idx + field];
  endfunction

  lc4_clkgen clkgen_i (
    .o_gwe    (gwe),
    .o_arst_n (arst_n)
  );

  // Instruction memory, PC only moves on a rising edge so the word follows in that step
  always @(cur_pc or loaded) begin
    cur_insn <= fetch_word(cur_pc);
  end

  for (genvar k = 0; k < REC_WORDS; k++) begin : g_exp
    assign exp_rec[k] = tdata[REC_BASE + REC_WORDS * rec_idx + k];
  end

  lc4_core dut_i (
    .gwe                 (gwe),
    .i_arst_n            (arst_n),
    .o_cur_pc            (cur_pc),
    .i_cur_insn          (cur_insn),
    .o_commit_valid      (commit_valid),
    .o_commit_pc         (commit_pc),
    .o_commit_insn       (commit_insn),
    .o_commit_regfile_we (commit_regfile_we),
    .o_commit_wsel       (commit_wsel),
    .o_commit_data       (commit_data),
    .o_commit_nzp_we     (commit_nzp_we),
    .o_commit_nzp        (commit_nzp)
  );

  lc4_checker checker_i (
    .gwe                 (gwe),
    .i_arst_n            (arst_n),
    .i_commit_valid      (commit_valid),
    .i_commit_pc         (commit_pc),
    .i_commit_insn       (commit_insn),
    .i_commit_regfile_we (commit_regfile_we),
    .i_commit_wsel       (commit_wsel),
    .i_commit_data       (commit_data),
    .i_commit_nzp_we     (commit_nzp_we),
    .i_commit_nzp        (commit_nzp),
    .i_exp_test          (exp_rec[0]),
    .i_exp_pc            (exp_rec[1]),
    .i_exp_insn          (exp_rec[2]),
    .i_exp_we            (exp_rec[3]),
    .i_exp_wsel          (exp_rec[4]),
    .i_exp_data          (exp_rec[5]),
    .i_exp_nzp_we        (exp_rec[6]),
    .i_exp_nzp           (exp_rec[7]),
    .i_num_recs          (num_recs),
    .i_timeout           (timed_out),
    .o_rec_idx           (rec_idx),
    .o_done              (done),
    .o_errors            (errors),
    .o_tests_passed      (tests_passed),
    .o_tests_failed      (tests_failed)
  );

  initial begin
    num_recs  = 0;
    num_taken = 0;
    cycles    = 0;
    $readmemh("tb/lc4_testdata.hex", tdata);
    loaded = 1'b1;
    // Records run until a test number of zero
    while ((num_recs < MAX_RECS) && !$isunknown(rec_field(num_recs, 0)) &&
           (rec_field(num_recs, 0) != 16'h0000)) begin
      if ((num_recs > 0) && (rec_field(num_recs, 1) != rec_field(num_recs - 1, 1) + 16'd1)) begin
        num_taken++; // PC jump between commits, a taken branch
      end
      num_recs++;
    end
    limit = 8 + 3 * num_recs + 2 * num_taken + 20;
    if (num_recs == 0) begin
      $display("No expected records found in tb/lc4_testdata.hex");
    end else begin
      while (!done && (cycles < limit)) begin
        @(negedge gwe); // Counters and done are stable here
        cycles++;
      end
      if (!done) begin
        timed_out = 1'b1;
        @(negedge gwe);
        $display("Run stopped at the cycle limit of %0d", limit);
      end
    end
    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if ((num_recs > 0) && !timed_out && (errors == 0) && (tests_failed == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
